// File: build.f
+incdir+test
design/alu_pkg.sv
design/exec_pkg.sv
design/exec_alu.sv
design/exec_regfile.sv
design/exec_issue.sv
design/exec_core.sv
test/exec_core_tb.sv

// File: design/alu_pkg.sv
// ----------------------------------------------------------
// ALU operation codes, width codes and flag bit positions
// ----------------------------------------------------------
`default_nettype none

package alu_pkg;

    // operation select, 6 bits wide to leave room for more ops
    typedef enum logic [5:0] {
        ALU_MOVE = 6'd0,
        ALU_ADD  = 6'd1,
        ALU_ADC  = 6'd2,   // add with carry in
        ALU_SUB  = 6'd3,
        ALU_SBC  = 6'd4,   // subtract with borrow in
        ALU_CP   = 6'd5,   // sub without write back
        ALU_AND  = 6'd6,
        ALU_OR   = 6'd7,
        ALU_XOR  = 6'd8
    } alu_op_e;

    // width codes, one-hot
    localparam logic [2:0] W_NONE = 3'b000;   // idle cycle
    localparam logic [2:0] W_BYTE = 3'b001;
    localparam logic [2:0] W_WORD = 3'b010;
    localparam logic [2:0] W_LONG = 3'b100;

    // flag byte layout: S Z 0 H 0 V N C
    localparam int FLAG_S = 7;
    localparam int FLAG_Z = 6;
    localparam int FLAG_H = 4;   // carry out of bit 3
    localparam int FLAG_V = 2;   // overflow or parity
    localparam int FLAG_N = 1;   // set by subtractions
    localparam int FLAG_C = 0;

endpackage

`default_nettype wire

// File: design/exec_alu.sv
// ----------------------------------------------------------
// width-aware ALU, registered result and flag byte
// ----------------------------------------------------------
`default_nettype none

module exec_alu (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen,
    input  logic [31:0]      op0,
    input  logic [31:0]      op1,
    input  logic [31:0]      imm,
    input  logic             sel_imm,
    input  logic [2:0]       w,         // one-hot width, 0 = no op
    input  alu_pkg::alu_op_e sel,
    output logic [31:0]      dout,
    output logic [2:0]       alu_we,
    output logic [7:0]       flags
);
    import alu_pkg::*;

    logic [31:0] op2;       // second operand after imm select
    logic [31:0] op2x;      // inverted for subtraction
    logic [31:0] sum;       // adder output, all chunks
    logic [31:0] logic_r;   // and/or/xor output
    logic [31:0] rslt;
    logic [7:0]  nx_f;
    logic        cin;
    logic        c_nib;     // carry out of bit 3
    logic        c_byte;
    logic        c_word;
    logic        c_long;
    logic        c_w;       // carry at selected width
    logic        is_sub;
    logic        ovf;

    // top bit at the selected width
    function automatic logic msb_at(input logic [2:0] wc, input logic [31:0] v);
        return wc[0] ? v[7] : wc[1] ? v[15] : v[31];
    endfunction

    function automatic logic zero_at(input logic [2:0] wc, input logic [31:0] v);
        return wc[0] ? (v[7:0] == 8'd0) : wc[1] ? (v[15:0] == 16'd0) : (v == 32'd0);
    endfunction

    // 1 when the number of ones is even
    function automatic logic par_at(input logic [2:0] wc, input logic [31:0] v);
        return wc[0] ? ~^v[7:0] : wc[1] ? ~^v[15:0] : ~^v;
    endfunction

    assign op2    = sel_imm ? imm : op1;
    assign is_sub = sel inside {ALU_SUB, ALU_SBC, ALU_CP};
    assign op2x   = is_sub ? ~op2 : op2;   // a - b done as a + ~b + 1

    // carry in, inverted borrow when subtracting
    always_comb begin
        case (sel)
            ALU_ADC:         cin = flags[FLAG_C];
            ALU_SUB, ALU_CP: cin = 1'b1;
            ALU_SBC:         cin = ~flags[FLAG_C];
            default:         cin = 1'b0;
        endcase
    end

    // chunked adder so every width gets its own carry
    always_comb begin
        {c_nib,  sum[3:0]}   = {1'b0, op0[3:0]}   + {1'b0, op2x[3:0]}   + {4'd0, cin};
        {c_byte, sum[7:4]}   = {1'b0, op0[7:4]}   + {1'b0, op2x[7:4]}   + {4'd0, c_nib};
        {c_word, sum[15:8]}  = {1'b0, op0[15:8]}  + {1'b0, op2x[15:8]}  + {8'd0, c_byte};
        {c_long, sum[31:16]} = {1'b0, op0[31:16]} + {1'b0, op2x[31:16]} + {16'd0, c_word};
    end

    assign c_w = w[0] ? c_byte : w[1] ? c_word : c_long;
    // same-sign inputs with a flipped result sign
    assign ovf = (msb_at(w, op0) == msb_at(w, op2x)) && (msb_at(w, sum) != msb_at(w, op0));

    always_comb begin
        case (sel)
            ALU_AND: logic_r = op0 & op2;
            ALU_OR:  logic_r = op0 | op2;
            default: logic_r = op0 ^ op2;
        endcase
    end

    // next result and flags, default is hold
    always_comb begin
        rslt = dout;
        nx_f = flags;
        case (sel)
            ALU_MOVE: rslt = op2;   // flags untouched
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                if (sel != ALU_CP)
                    rslt = sum;     // cp keeps dout
                nx_f[FLAG_S] = msb_at(w, sum);
                nx_f[FLAG_Z] = zero_at(w, sum);
                nx_f[FLAG_H] = c_nib ^ is_sub;   // half borrow on sub
                nx_f[FLAG_V] = ovf;
                nx_f[FLAG_N] = is_sub;
                nx_f[FLAG_C] = c_w ^ is_sub;     // borrow on sub
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                rslt = logic_r;
                nx_f[FLAG_S] = msb_at(w, logic_r);
                nx_f[FLAG_Z] = zero_at(w, logic_r);
                nx_f[FLAG_H] = (sel == ALU_AND);
                nx_f[FLAG_V] = par_at(w, logic_r);   // parity, not overflow
                nx_f[FLAG_N] = 1'b0;
                nx_f[FLAG_C] = 1'b0;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout   <= 32'd0;
            flags  <= 8'd0;
            alu_we <= W_NONE;
        end else if (cen) begin
            if (w != W_NONE) begin
                dout  <= rslt;
                flags <= nx_f;
            end
            // compare only touches flags
            alu_we <= (sel == ALU_CP) ? W_NONE : w;
        end
    end

    // sequencer must never present more than one width bit
    a_w_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) cen |-> $onehot0(w)
    ) else $error("exec_alu: width code %b is not one-hot", w);

endmodule

`default_nettype wire

// File: design/exec_core.sv
// ----------------------------------------------------------
// execution slice top: issue stage, register bank, ALU
// ----------------------------------------------------------
`default_nettype none

module exec_core #(
    parameter  int NUM_REGS = exec_pkg::DEF_NUM_REGS,
    localparam int AW       = $clog2(NUM_REGS)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen,        // stall when low
    input  logic [2:0]       w,
    input  alu_pkg::alu_op_e sel,
    input  logic             sel_imm,
    input  logic [31:0]      imm,
    input  logic [AW-1:0]    src_a,
    input  logic [AW-1:0]    src_b,
    input  logic [AW-1:0]    dst,
    output logic [31:0]      result,
    output logic [2:0]       result_we,
    output logic [AW-1:0]    result_dst,
    output logic [7:0]       flags
);

    logic [AW-1:0] rd_addr_a;
    logic [AW-1:0] rd_addr_b;
    logic [31:0]   rd_data_a;
    logic [31:0]   rd_data_b;
    logic [31:0]   op0;
    logic [31:0]   op1;
    logic [AW-1:0] wr_addr;
    logic [31:0]   wr_data;
    logic [2:0]    wr_we;

    exec_issue #(.NUM_REGS(NUM_REGS)) exec_issue_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen        (cen),
        .w          (w),
        .src_a      (src_a),
        .src_b      (src_b),
        .dst        (dst),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .dout       (result),
        .alu_we     (result_we),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .op0        (op0),
        .op1        (op1),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_we      (wr_we),
        .result_dst (result_dst)
    );

    exec_regfile #(.NUM_REGS(NUM_REGS)) exec_regfile_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_addr   (wr_addr),
        .wr_we     (wr_we),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    exec_alu exec_alu_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen     (cen),
        .op0     (op0),
        .op1     (op1),
        .imm     (imm),
        .sel_imm (sel_imm),
        .w       (w),
        .sel     (sel),
        .dout    (result),
        .alu_we  (result_we),
        .flags   (flags)
    );

endmodule

`default_nettype wire

// File: design/exec_issue.sv
// ----------------------------------------------------------
// operand read with lane-merged forwarding, writeback
// ----------------------------------------------------------
`default_nettype none

module exec_issue #(
    parameter  int NUM_REGS = exec_pkg::DEF_NUM_REGS,
    localparam int AW       = $clog2(NUM_REGS)
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          cen,
    input  logic [2:0]    w,            // width of the op being issued
    input  logic [AW-1:0] src_a,
    input  logic [AW-1:0] src_b,
    input  logic [AW-1:0] dst,
    input  logic [31:0]   rd_data_a,
    input  logic [31:0]   rd_data_b,
    input  logic [31:0]   dout,         // pending ALU result
    input  logic [2:0]    alu_we,       // its width, 0 = nothing pending
    output logic [AW-1:0] rd_addr_a,
    output logic [AW-1:0] rd_addr_b,
    output logic [31:0]   op0,
    output logic [31:0]   op1,
    output logic [AW-1:0] wr_addr,
    output logic [31:0]   wr_data,
    output logic [2:0]    wr_we,
    output logic [AW-1:0] result_dst
);
    import alu_pkg::*;
    import exec_pkg::*;

    logic [AW-1:0] pend_dst;    // destination of the op inside the ALU
    logic          pend_vld;
    logic [31:0]   pend_mask;   // lanes the pending op will write
    logic [31:0]   fwd_mask_a;
    logic [31:0]   fwd_mask_b;

    // follows the ALU result register, same enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pend_dst <= '0;
        else if (cen && w != W_NONE)
            pend_dst <= dst;
    end

    assign pend_vld  = (alu_we != W_NONE);
    assign pend_mask = lane_mask(alu_we);

    // register bank lookup, bank not yet written for the pending op
    assign rd_addr_a = src_a;
    assign rd_addr_b = src_b;

    // only matching sources take the forwarded lanes
    assign fwd_mask_a = (pend_vld && src_a == pend_dst) ? pend_mask : 32'd0;
    assign fwd_mask_b = (pend_vld && src_b == pend_dst) ? pend_mask : 32'd0;

    // pending lanes from dout, the rest from the bank
    assign op0 = (dout & fwd_mask_a) | (rd_data_a & ~fwd_mask_a);
    assign op1 = (dout & fwd_mask_b) | (rd_data_b & ~fwd_mask_b);

    // writeback lands on the next edge
    assign wr_addr    = pend_dst;
    assign wr_data    = dout;
    assign wr_we      = alu_we;
    assign result_dst = pend_dst;

    // index must exist in the bank, or the write is lost
    a_dst_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        (cen && w != W_NONE) |-> (int'(dst) < NUM_REGS)
    ) else $error("exec_issue: destination %0d outside the bank", dst);

endmodule

`default_nettype wire

// File: design/exec_pkg.sv
// ----------------------------------------------------------
// register file sizing and lane masks for width codes
// ----------------------------------------------------------
`default_nettype none

package exec_pkg;

    // register count of the bank, one bank only
    localparam int DEF_NUM_REGS = 16;

    // bits of a 32-bit register touched by a width code
    function automatic logic [31:0] lane_mask(input logic [2:0] wc);
        logic [31:0] m;
        case (wc)
            alu_pkg::W_BYTE: m = 32'h0000_00ff;
            alu_pkg::W_WORD: m = 32'h0000_ffff;
            alu_pkg::W_LONG: m = 32'hffff_ffff;
            default:         m = 32'h0000_0000;   // idle or illegal code
        endcase
        return m;
    endfunction

endpackage

`default_nettype wire

// File: design/exec_regfile.sv
// ----------------------------------------------------------
// register bank, two async read ports, lane-masked write
// ----------------------------------------------------------
`default_nettype none

module exec_regfile #(
    parameter  int NUM_REGS = exec_pkg::DEF_NUM_REGS,
    localparam int AW       = $clog2(NUM_REGS)
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic [AW-1:0] rd_addr_a,
    input  logic [AW-1:0] rd_addr_b,
    input  logic [AW-1:0] wr_addr,
    input  logic [2:0]    wr_we,       // width code of the write
    input  logic [31:0]   wr_data,
    output logic [31:0]   rd_data_a,
    output logic [31:0]   rd_data_b
);
    import exec_pkg::*;

    logic [31:0] regs [NUM_REGS];
    logic [31:0] wr_mask;    // lanes written this cycle

    assign wr_mask = lane_mask(wr_we);

    // reads see the old value during a write
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= 32'd0;
        end else if (|wr_we) begin
            // byte and word writes keep the upper bits
            regs[wr_addr] <= (regs[wr_addr] & ~wr_mask) | (wr_data & wr_mask);
        end
    end

    // writeback width comes straight from the ALU pipeline register
    a_we_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(wr_we)
    ) else $error("exec_regfile: write enable %b is not one-hot", wr_we);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -Mdir obj_dir \
        --top-module exec_core_tb -f build.f; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/Vexec_core_tb 2>&1)"
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1

// File: test/exec_model.svh
// ----------------------------------------------------------
// reference ALU model and architectural register mirror
// ----------------------------------------------------------
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

logic [31:0] mirror [16];   // register state as the program sees it

// expected lanes, flags and write enable of one micro-operation
function automatic void alu_ref(
    input  alu_op_e     op,
    input  logic [2:0]  wc,
    input  logic [31:0] a_reg,      // first source register value
    input  logic [31:0] b_reg,      // second source register value
    input  logic [31:0] imm_v,
    input  logic        use_imm,
    input  logic [7:0]  f_in,       // flags before the op
    output logic [31:0] res,
    output logic [7:0]  f_out,
    output logic [2:0]  we
);
    logic [31:0] m;
    logic [31:0] hbit;    // sign bit of the width
    logic [31:0] a;
    logic [31:0] b;
    logic [33:0] a_ext;   // sign extended operands
    logic [33:0] b_ext;
    logic [33:0] s_ext;   // exact signed result
    logic [33:0] u_sum;   // exact unsigned sum
    logic        ci;
    logic        sub;
    int          hb;
    m     = lane_mask(wc);
    hbit  = (m >> 1) + 32'd1;
    hb    = (wc == W_BYTE) ? 7 : (wc == W_WORD) ? 15 : 31;
    a     = a_reg & m;
    b     = (use_imm ? imm_v : b_reg) & m;
    sub   = op inside {ALU_SUB, ALU_SBC, ALU_CP};
    ci    = (op == ALU_ADC || op == ALU_SBC) ? f_in[FLAG_C] : 1'b0;   // carry or borrow
    a_ext = ((a & hbit) != 32'd0) ? {2'b11, a | ~m} : {2'b00, a};
    b_ext = ((b & hbit) != 32'd0) ? {2'b11, b | ~m} : {2'b00, b};
    f_out = f_in;
    we    = (op == ALU_CP) ? W_NONE : wc;
    case (op)
        ALU_MOVE: res = b;   // flags kept
        ALU_AND, ALU_OR, ALU_XOR: begin
            res = (op == ALU_AND) ? (a & b) : (op == ALU_OR) ? (a | b) : (a ^ b);
            f_out = 8'd0;
            f_out[FLAG_H] = (op == ALU_AND);
            f_out[FLAG_V] = ~^res;   // even parity of the lanes
        end
        default: begin
            f_out = 8'd0;
            if (sub) begin
                res   = (a - b - {31'd0, ci}) & m;
                s_ext = a_ext - b_ext - {33'd0, ci};
                f_out[FLAG_C] = ({2'b00, a} < {2'b00, b} + {33'd0, ci});   // borrow
                f_out[FLAG_H] = ({1'b0, a[3:0]} < {1'b0, b[3:0]} + {4'd0, ci});
                f_out[FLAG_N] = 1'b1;
            end else begin
                res   = (a + b + {31'd0, ci}) & m;
                s_ext = a_ext + b_ext + {33'd0, ci};
                u_sum = {2'b00, a} + {2'b00, b} + {33'd0, ci};
                f_out[FLAG_C] = (u_sum > {2'b00, m});
                f_out[FLAG_H] = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, ci}) > 5'd15;
            end
            // signed result outside the range of the width
            f_out[FLAG_V] = ((s_ext[33] ? ~s_ext : s_ext) >> hb) != 34'd0;
        end
    endcase
    if (op != ALU_MOVE) begin
        f_out[FLAG_S] = (res & hbit) != 32'd0;
        f_out[FLAG_Z] = (res == 32'd0);
    end
endfunction

function automatic void mirror_clear();
    mirror = '{default: 32'd0};
endfunction

// same lane rule as the register bank write
function automatic void mirror_write(
    input logic [3:0]  idx,
    input logic [2:0]  we,
    input logic [31:0] val
);
    logic [31:0] m;
    m = lane_mask(we);
    mirror[idx] = (mirror[idx] & ~m) | (val & m);
endfunction

`endif

// File: test/exec_core_tb.sv
// ----------------------------------------------------------
// testbench for the execution slice, random and directed ops
// ----------------------------------------------------------
`default_nettype none

module exec_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import alu_pkg::*;
    import exec_pkg::*;

    localparam int          NUM_REGS    = 16;
    localparam int          RST_CYCLES  = 10;
    localparam int          N_OPS       = 500;
    localparam int          CYCLE_LIMIT = RST_CYCLES + 2 * N_OPS + 190;   // 1200
    localparam logic [31:0] SEED        = 32'h8ba1_8f45;

    typedef struct packed {
        int          due;     // cycle count at which to compare
        logic [31:0] res;
        logic [31:0] mask;    // lanes of result worth checking
        logic [2:0]  we;
        logic [3:0]  dst;
        logic [7:0]  flags;
    } expect_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        cen;
    logic [2:0]  w;
    alu_op_e     sel;
    logic        sel_imm;
    logic [31:0] imm;
    logic [3:0]  src_a;
    logic [3:0]  src_b;
    logic [3:0]  dst;
    logic [31:0] result;
    logic [2:0]  result_we;
    logic [3:0]  result_dst;
    logic [7:0]  flags;

    expect_t     exp_q [$];
    logic [31:0] exp_res;     // outputs expected after the last driven edge
    logic [31:0] exp_mask;
    logic [2:0]  exp_we;
    logic [3:0]  exp_dst;
    logic [7:0]  exp_flags;
    int          cyc = 0;
    int          n_issued = 0;

    `include "exec_model.svh"

    exec_core #(.NUM_REGS(NUM_REGS)) exec_core_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen        (cen),
        .w          (w),
        .sel        (sel),
        .sel_imm    (sel_imm),
        .imm        (imm),
        .src_a      (src_a),
        .src_b      (src_b),
        .dst        (dst),
        .result     (result),
        .result_we  (result_we),
        .result_dst (result_dst),
        .flags      (flags)
    );

    always #50 clk = ~clk;   // 100 ns period

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, what, got, want);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // queued for the negedge after the accepting edge
    task automatic push_expect();
        expect_t e;
        e.due   = cyc + 2;
        e.res   = exp_res;
        e.mask  = exp_mask;
        e.we    = exp_we;
        e.dst   = exp_dst;
        e.flags = exp_flags;
        exp_q.push_back(e);
    endtask

    task automatic issue_op(input alu_op_e op, input logic [2:0] wc, input logic [3:0] sa,
                            input logic [3:0] sb, input logic [3:0] d, input logic use_imm,
                            input logic [31:0] imm_v);
        logic [31:0] r;
        logic [7:0]  f;
        logic [2:0]  we_x;
        @(posedge clk);
        cen     <= 1'b1;
        w       <= wc;
        sel     <= op;
        sel_imm <= use_imm;
        imm     <= imm_v;
        src_a   <= sa;
        src_b   <= sb;
        dst     <= d;
        alu_ref(op, wc, mirror[sa], mirror[sb], imm_v, use_imm, exp_flags, r, f, we_x);
        mirror_write(d, we_x, r);
        exp_flags = f;
        exp_we    = we_x;
        exp_dst   = d;   // taken even by compare
        if (op != ALU_CP) begin   // compare leaves the last result on dout
            exp_res  = r;
            exp_mask = lane_mask(wc);
        end
        push_expect();
        n_issued++;
    endtask

    // cen low with junk on the other inputs
    task automatic stall_cycle();
        @(posedge clk);
        cen   <= 1'b0;
        w     <= 3'b001 << $urandom_range(2, 0);
        sel   <= alu_op_e'(6'($urandom_range(8, 0)));
        src_a <= 4'($urandom_range(15, 0));
        dst   <= 4'($urandom_range(15, 0));
        imm   <= $urandom();
        push_expect();   // everything holds
    endtask

    task automatic run_directed();
        issue_op(ALU_ADD,  W_LONG, 4'd1, 4'd2, 4'd3,  1'b0, 32'd0);           // zero, Z set
        issue_op(ALU_MOVE, W_LONG, 4'd0, 4'd0, 4'd1,  1'b1, 32'h1234_56f8);
        issue_op(ALU_MOVE, W_LONG, 4'd0, 4'd0, 4'd2,  1'b1, 32'h0000_7f0f);
        issue_op(ALU_MOVE, W_LONG, 4'd0, 4'd0, 4'd3,  1'b1, 32'hffff_ffff);
        issue_op(ALU_ADD,  W_BYTE, 4'd1, 4'd2, 4'd4,  1'b0, 32'd0);           // f8+0f carry
        issue_op(ALU_ADC,  W_WORD, 4'd2, 4'd2, 4'd5,  1'b0, 32'd0);           // overflow
        issue_op(ALU_ADD,  W_LONG, 4'd3, 4'd0, 4'd6,  1'b1, 32'd1);           // wraps to 0
        issue_op(ALU_ADC,  W_LONG, 4'd1, 4'd3, 4'd7,  1'b0, 32'd0);
        issue_op(ALU_MOVE, W_BYTE, 4'd0, 4'd0, 4'd1,  1'b1, 32'h0000_00aa);   // flags kept
        issue_op(ALU_SUB,  W_BYTE, 4'd2, 4'd3, 4'd8,  1'b0, 32'd0);
        issue_op(ALU_SBC,  W_WORD, 4'd1, 4'd2, 4'd9,  1'b0, 32'd0);
        issue_op(ALU_SUB,  W_LONG, 4'd0, 4'd3, 4'd10, 1'b0, 32'd0);           // borrow
        issue_op(ALU_SBC,  W_LONG, 4'd2, 4'd2, 4'd11, 1'b0, 32'd0);
        issue_op(ALU_CP,   W_LONG, 4'd1, 4'd2, 4'd2,  1'b0, 32'd0);           // r2 untouched
        issue_op(ALU_MOVE, W_LONG, 4'd0, 4'd2, 4'd12, 1'b0, 32'd0);           // read r2 back
        issue_op(ALU_CP,   W_BYTE, 4'd3, 4'd0, 4'd3,  1'b1, 32'h0000_00ff);
        issue_op(ALU_AND,  W_BYTE, 4'd1, 4'd2, 4'd13, 1'b0, 32'd0);
        issue_op(ALU_OR,   W_WORD, 4'd1, 4'd2, 4'd13, 1'b0, 32'd0);
        issue_op(ALU_XOR,  W_LONG, 4'd1, 4'd3, 4'd14, 1'b0, 32'd0);
        issue_op(ALU_AND,  W_LONG, 4'd3, 4'd0, 4'd14, 1'b1, 32'h8000_0001);
        issue_op(ALU_XOR,  W_BYTE, 4'd3, 4'd3, 4'd15, 1'b0, 32'd0);           // zero, even
        // forwarding chain, byte over a pending long
        issue_op(ALU_MOVE, W_LONG, 4'd0, 4'd0, 4'd5,  1'b1, 32'hdead_beef);
        issue_op(ALU_MOVE, W_BYTE, 4'd0, 4'd0, 4'd5,  1'b1, 32'h0000_0012);
        issue_op(ALU_ADD,  W_LONG, 4'd5, 4'd5, 4'd6,  1'b0, 32'd0);           // merged r5
        issue_op(ALU_ADD,  W_WORD, 4'd6, 4'd5, 4'd6,  1'b0, 32'd0);
        issue_op(ALU_SUB,  W_LONG, 4'd6, 4'd6, 4'd7,  1'b0, 32'd0);
        stall_cycle();
        issue_op(ALU_ADD,  W_LONG, 4'd7, 4'd6, 4'd7,  1'b0, 32'd0);           // across stall
    endtask

    task automatic run_random();
        alu_op_e    op;
        logic [2:0] wc;
        logic [3:0] sa;
        logic [3:0] sb;
        logic [3:0] d;
        logic [3:0] last_dst;
        last_dst = 4'd0;
        while (n_issued < N_OPS) begin
            op = alu_op_e'(6'($urandom_range(8, 0)));
            case ($urandom_range(2, 0))
                0:       wc = W_BYTE;
                1:       wc = W_WORD;
                default: wc = W_LONG;
            endcase
            // half the sources hit the pending destination
            sa = ($urandom_range(1, 0) == 1) ? last_dst : 4'($urandom_range(15, 0));
            sb = ($urandom_range(1, 0) == 1) ? last_dst : 4'($urandom_range(15, 0));
            d  = 4'($urandom_range(15, 0));
            if ($urandom_range(3, 0) == 0)
                stall_cycle();   // at most one per op
            issue_op(op, wc, sa, sb, d, $urandom_range(3, 0) == 0, $urandom());
            last_dst = d;
        end
    endtask

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : compare_outputs
        expect_t e;
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            check_value(result & e.mask, e.res, "result");
            check_value(32'(result_we), 32'(e.we), "result_we");
            check_value(32'(result_dst), 32'(e.dst), "result_dst");
            check_value(32'(flags), 32'(e.flags), "flags");
        end
    end

    initial begin
        void'($urandom(SEED));
        arst_n  = 1'b0;
        cen     = 1'b0;
        w       = W_NONE;
        sel     = ALU_MOVE;
        sel_imm = 1'b0;
        imm     = 32'd0;
        src_a   = 4'd0;
        src_b   = 4'd0;
        dst     = 4'd0;
        mirror_clear();
        exp_res   = 32'd0;
        exp_mask  = 32'hffff_ffff;
        exp_we    = W_NONE;
        exp_dst   = 4'd0;
        exp_flags = 8'd0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value(32'(result_we), 32'(W_NONE), "result_we after reset");
        check_value(32'(flags), 32'd0, "flags after reset");
        check_value(result, 32'd0, "result after reset");
        run_directed();
        run_random();
        stall_cycle();   // park the sequencer
        while (exp_q.size() != 0)
            @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
